// ==== compile.f ====
hw/exu_pkg.sv
hw/exu_alu.sv
hw/exu_lsu.sv
hw/exu_commit.sv
hw/exu_top.sv
tb/exu_wb_mem.sv
tb/exu_properties.sv
tb/exu_tb.sv

// ==== hw/exu_alu.sv ====
// alu with operand select, word-cut variants, registered result and zero/less flags
`timescale 1ns/1ns

module exu_alu (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_start,
  input  logic [exu_pkg::XLEN-1:0] i_rs1,
  input  logic [exu_pkg::XLEN-1:0] i_pc,
  input  logic [exu_pkg::XLEN-1:0] i_rs2,
  input  logic [exu_pkg::XLEN-1:0] i_imm,
  input  exu_pkg::a_src_e         i_a_src,
  input  exu_pkg::b_src_e         i_b_src,
  input  exu_pkg::alu_op_e        i_alu_op,
  input  logic                    i_word_cut,
  output logic [exu_pkg::XLEN-1:0] o_result,
  output logic                    o_zero,
  output logic                    o_less
);

  logic [exu_pkg::XLEN-1:0] src_a;
  logic [exu_pkg::XLEN-1:0] src_b;
  logic [exu_pkg::XLEN-1:0] full_res;
  logic [31:0]              word_res;
  logic [exu_pkg::XLEN-1:0] res;
  logic                     slt;
  logic                     sltu;

  assign src_a = (i_a_src == exu_pkg::A_PC) ? i_pc : i_rs1;

  always_comb begin
    case (i_b_src)
      exu_pkg::B_RS2:  src_b = i_rs2;
      exu_pkg::B_IMM:  src_b = i_imm;
      exu_pkg::B_FOUR: src_b = 64'd4;
      default:         src_b = i_rs2;
    endcase
  end

  assign slt  = $signed(src_a) < $signed(src_b);
  assign sltu = src_a < src_b;

  always_comb begin
    case (i_alu_op)
      exu_pkg::ALU_ADD:    full_res = src_a + src_b;
      exu_pkg::ALU_SUB:    full_res = src_a - src_b;
      exu_pkg::ALU_SLL:    full_res = src_a << src_b[5:0];
      exu_pkg::ALU_SLT:    full_res = {63'd0, slt};
      exu_pkg::ALU_SLTU:   full_res = {63'd0, sltu};
      exu_pkg::ALU_XOR:    full_res = src_a ^ src_b;
      exu_pkg::ALU_SRL:    full_res = src_a >> src_b[5:0];
      exu_pkg::ALU_SRA:    full_res = $signed(src_a) >>> src_b[5:0];
      exu_pkg::ALU_OR:     full_res = src_a | src_b;
      exu_pkg::ALU_AND:    full_res = src_a & src_b;
      exu_pkg::ALU_COPY_B: full_res = src_b;
      default:             full_res = '0;
    endcase
  end

  // *w forms, 5-bit shift amount
  always_comb begin
    case (i_alu_op)
      exu_pkg::ALU_ADD: word_res = src_a[31:0] + src_b[31:0];
      exu_pkg::ALU_SUB: word_res = src_a[31:0] - src_b[31:0];
      exu_pkg::ALU_SLL: word_res = src_a[31:0] << src_b[4:0];
      exu_pkg::ALU_SRL: word_res = src_a[31:0] >> src_b[4:0];
      exu_pkg::ALU_SRA: word_res = $signed(src_a[31:0]) >>> src_b[4:0];
      default:          word_res = full_res[31:0];
    endcase
  end

  assign res = i_word_cut ? {{32{word_res[31]}}, word_res} : full_res;

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      o_result <= res;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_zero <= 1'b0;
      o_less <= 1'b0;
    end else if (i_start) begin
      o_zero <= (res == '0);
      o_less <= (i_alu_op == exu_pkg::ALU_SLTU) ? sltu : slt;  // bltu/bgeu come in as sltu
    end
  end

endmodule

// ==== hw/exu_commit.sv ====
// commit: issue handshake, busy tracking, branch decision, next pc, write-back mux, trap
`timescale 1ns/1ns

module exu_commit (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_valid,
  input  logic [exu_pkg::XLEN-1:0] i_pc,
  input  logic [exu_pkg::XLEN-1:0] i_rs1,
  input  logic [exu_pkg::XLEN-1:0] i_imm,
  input  exu_pkg::branch_e        i_branch,
  input  exu_pkg::mem_op_e        i_mem_op,
  input  exu_pkg::wb_sel_e        i_wb_sel,
  input  logic                    i_rd_en,
  input  logic                    i_invalid,
  input  logic [exu_pkg::XLEN-1:0] i_alu_result,
  input  logic                    i_zero,
  input  logic                    i_less,
  input  logic [exu_pkg::XLEN-1:0] i_load_data,
  input  logic                    i_mem_done,
  output logic                    o_ready,
  output logic                    o_start,
  output logic                    o_done,
  output logic                    o_rd_we,
  output logic [exu_pkg::XLEN-1:0] o_rd_data,
  output logic [exu_pkg::XLEN-1:0] o_next_pc,
  output logic                    o_trap
);

  logic                     busy;
  logic                     finish;
  logic                     taken;
  logic                     is_mem_q;
  logic                     rd_en_q;
  logic                     invalid_q;
  exu_pkg::branch_e         branch_q;
  exu_pkg::wb_sel_e         wb_sel_q;
  logic [exu_pkg::XLEN-1:0] pc_q;
  logic [exu_pkg::XLEN-1:0] rs1_q;
  logic [exu_pkg::XLEN-1:0] imm_q;
  logic [exu_pkg::XLEN-1:0] pc_base;
  logic [exu_pkg::XLEN-1:0] pc_off;

  assign o_ready = !busy;
  assign o_start = i_valid && o_ready;
  assign finish  = busy && !o_done && (is_mem_q ? i_mem_done : 1'b1);

  always_comb begin
    case (branch_q)
      exu_pkg::BR_JAL, exu_pkg::BR_JALR: taken = 1'b1;
      exu_pkg::BR_BEQ: taken = i_zero;
      exu_pkg::BR_BNE: taken = !i_zero;
      exu_pkg::BR_BLT: taken = i_less;
      exu_pkg::BR_BGE: taken = !i_less;
      default:         taken = 1'b0;
    endcase
  end

  assign pc_base = (branch_q == exu_pkg::BR_JALR && !invalid_q) ? rs1_q : pc_q;
  assign pc_off  = (taken && !invalid_q) ? imm_q : 64'd4;

  always_ff @(posedge i_clk) begin
    if (o_start) begin
      pc_q     <= i_pc;
      rs1_q    <= i_rs1;
      imm_q    <= i_imm;
      branch_q <= i_branch;
      wb_sel_q <= i_wb_sel;
      is_mem_q <= (i_mem_op != exu_pkg::MEM_NONE);
      rd_en_q  <= i_rd_en;
      invalid_q <= i_invalid;
    end
    if (finish) begin
      o_rd_data <= (wb_sel_q == exu_pkg::WB_MEM) ? i_load_data : i_alu_result;
      o_next_pc <= pc_base + pc_off;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      busy    <= 1'b0;
      o_done  <= 1'b0;
      o_rd_we <= 1'b0;
      o_trap  <= 1'b0;
    end else begin
      o_done <= finish;
      if (o_start) begin
        busy <= 1'b1;
      end else if (o_done) begin
        busy <= 1'b0;  // ready again after the done cycle
      end
      if (finish) begin
        o_rd_we <= rd_en_q && !invalid_q;
        o_trap  <= invalid_q;
      end
    end
  end

endmodule

// ==== hw/exu_lsu.sv ====
// load/store unit: address add, store lane steering, wishbone classic master, load extension
`timescale 1ns/1ns

module exu_lsu (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_start,
  input  logic [exu_pkg::XLEN-1:0]     i_rs1,
  input  logic [exu_pkg::XLEN-1:0]     i_imm,
  input  logic [exu_pkg::XLEN-1:0]     i_rs2,
  input  exu_pkg::mem_op_e            i_mem_op,
  input  logic [exu_pkg::XLEN-1:0]     i_wb_dat,
  input  logic                        i_wb_ack,
  output logic                        o_wb_cyc,
  output logic                        o_wb_stb,
  output logic                        o_wb_we,
  output logic [exu_pkg::XLEN-1:0]     o_wb_adr,
  output logic [exu_pkg::WB_SEL_W-1:0] o_wb_sel,
  output logic [exu_pkg::XLEN-1:0]     o_wb_dat,
  output logic [exu_pkg::XLEN-1:0]     o_load_data,
  output logic                        o_mem_done
);

  typedef enum logic {
    S_IDLE,
    S_BUS
  } state_e;

  state_e                       state;
  exu_pkg::mem_op_e             op_q;
  logic [exu_pkg::OFF_W-1:0]    off_q;
  logic [exu_pkg::XLEN-1:0]     addr;
  logic [exu_pkg::OFF_W-1:0]    off;
  logic [exu_pkg::WB_SEL_W-1:0] size_sel;
  logic                         is_store;
  logic [exu_pkg::XLEN-1:0]     rd_shift;

  assign addr     = i_rs1 + i_imm;
  assign off      = addr[exu_pkg::OFF_W-1:0];
  assign is_store = i_mem_op[3];

  always_comb begin
    case (i_mem_op)
      exu_pkg::MEM_LB, exu_pkg::MEM_LBU, exu_pkg::MEM_SB: size_sel = exu_pkg::SEL_B;
      exu_pkg::MEM_LH, exu_pkg::MEM_LHU, exu_pkg::MEM_SH: size_sel = exu_pkg::SEL_H;
      exu_pkg::MEM_LW, exu_pkg::MEM_LWU, exu_pkg::MEM_SW: size_sel = exu_pkg::SEL_W;
      default:                                            size_sel = exu_pkg::SEL_D;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (i_start && i_mem_op != exu_pkg::MEM_NONE) begin
            state <= S_BUS;
          end
        end
        S_BUS: begin
          if (i_wb_ack) begin
            state <= S_IDLE;  // cyc/stb drop next cycle
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // request fields, held for the whole transfer
  always_ff @(posedge i_clk) begin
    if (state == S_IDLE && i_start) begin
      op_q     <= i_mem_op;
      off_q    <= off;
      o_wb_adr <= {addr[exu_pkg::XLEN-1:exu_pkg::OFF_W], {exu_pkg::OFF_W{1'b0}}};
      o_wb_we  <= is_store;
      o_wb_sel <= size_sel << off;
      o_wb_dat <= i_rs2 << {off, 3'b000};
    end
  end

  assign o_wb_cyc   = (state == S_BUS);
  assign o_wb_stb   = o_wb_cyc;
  assign o_mem_done = o_wb_cyc && i_wb_ack;

  assign rd_shift = i_wb_dat >> {off_q, 3'b000};

  always_comb begin
    case (op_q)
      exu_pkg::MEM_LB:  o_load_data = {{56{rd_shift[7]}}, rd_shift[7:0]};
      exu_pkg::MEM_LBU: o_load_data = {56'd0, rd_shift[7:0]};
      exu_pkg::MEM_LH:  o_load_data = {{48{rd_shift[15]}}, rd_shift[15:0]};
      exu_pkg::MEM_LHU: o_load_data = {48'd0, rd_shift[15:0]};
      exu_pkg::MEM_LW:  o_load_data = {{32{rd_shift[31]}}, rd_shift[31:0]};
      exu_pkg::MEM_LWU: o_load_data = {32'd0, rd_shift[31:0]};
      default:          o_load_data = rd_shift;  // ld, stores ignore it
    endcase
  end

endmodule

// ==== hw/exu_pkg.sv ====
// data widths, enums for the decoded instruction fields, wishbone byte-select masks
package exu_pkg;

  localparam int XLEN     = 64;
  localparam int WB_SEL_W = 8;
  localparam int OFF_W    = 3;  // byte offset inside a doubleword

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_COPY_B = 4'd10  // lui
  } alu_op_e;

  typedef enum logic {
    A_RS1 = 1'b0,
    A_PC  = 1'b1
  } a_src_e;

  typedef enum logic [1:0] {
    B_RS2  = 2'd0,
    B_IMM  = 2'd1,
    B_FOUR = 2'd2
  } b_src_e;

  typedef enum logic [2:0] {
    BR_NONE = 3'b000,
    BR_JAL  = 3'b001,
    BR_JALR = 3'b010,
    BR_BEQ  = 3'b100,
    BR_BNE  = 3'b101,
    BR_BLT  = 3'b110,
    BR_BGE  = 3'b111
  } branch_e;

  // bit 3 set for stores
  typedef enum logic [3:0] {
    MEM_NONE = 4'd0,
    MEM_LB   = 4'd1,
    MEM_LBU  = 4'd2,
    MEM_LH   = 4'd3,
    MEM_LHU  = 4'd4,
    MEM_LW   = 4'd5,
    MEM_LWU  = 4'd6,
    MEM_LD   = 4'd7,
    MEM_SB   = 4'd8,
    MEM_SH   = 4'd9,
    MEM_SW   = 4'd10,
    MEM_SD   = 4'd11
  } mem_op_e;

  typedef enum logic {
    WB_ALU = 1'b0,
    WB_MEM = 1'b1
  } wb_sel_e;

  // byte lanes per access size, before shifting by the offset
  localparam logic [WB_SEL_W-1:0] SEL_B = 8'h01;
  localparam logic [WB_SEL_W-1:0] SEL_H = 8'h03;
  localparam logic [WB_SEL_W-1:0] SEL_W = 8'h0f;
  localparam logic [WB_SEL_W-1:0] SEL_D = 8'hff;

endpackage

// ==== hw/exu_top.sv ====
// execute stage top: alu, load/store unit and commit wired to the outside
`timescale 1ns/1ns

module exu_top (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_valid,
  input  logic [exu_pkg::XLEN-1:0]     i_pc,
  input  logic [exu_pkg::XLEN-1:0]     i_rs1,
  input  logic [exu_pkg::XLEN-1:0]     i_rs2,
  input  logic [exu_pkg::XLEN-1:0]     i_imm,
  input  exu_pkg::a_src_e             i_a_src,
  input  exu_pkg::b_src_e             i_b_src,
  input  exu_pkg::alu_op_e            i_alu_op,
  input  logic                        i_word_cut,
  input  exu_pkg::branch_e            i_branch,
  input  exu_pkg::mem_op_e            i_mem_op,
  input  exu_pkg::wb_sel_e            i_wb_sel,
  input  logic                        i_rd_en,
  input  logic                        i_invalid,
  output logic                        o_ready,
  output logic                        o_done,
  output logic                        o_rd_we,
  output logic [exu_pkg::XLEN-1:0]     o_rd_data,
  output logic [exu_pkg::XLEN-1:0]     o_next_pc,
  output logic                        o_trap,
  output logic                        o_wb_cyc,
  output logic                        o_wb_stb,
  output logic                        o_wb_we,
  output logic [exu_pkg::XLEN-1:0]     o_wb_adr,
  output logic [exu_pkg::WB_SEL_W-1:0] o_wb_sel,
  output logic [exu_pkg::XLEN-1:0]     o_wb_dat,
  input  logic [exu_pkg::XLEN-1:0]     i_wb_dat,
  input  logic                        i_wb_ack
);

  logic                     start;
  logic [exu_pkg::XLEN-1:0] alu_result;
  logic                     zero;
  logic                     less;
  logic [exu_pkg::XLEN-1:0] load_data;
  logic                     mem_done;

  exu_alu u_alu (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_start    (start),
    .i_rs1      (i_rs1),
    .i_pc       (i_pc),
    .i_rs2      (i_rs2),
    .i_imm      (i_imm),
    .i_a_src    (i_a_src),
    .i_b_src    (i_b_src),
    .i_alu_op   (i_alu_op),
    .i_word_cut (i_word_cut),
    .o_result   (alu_result),
    .o_zero     (zero),
    .o_less     (less)
  );

  exu_lsu u_lsu (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_start     (start),
    .i_rs1       (i_rs1),
    .i_imm       (i_imm),
    .i_rs2       (i_rs2),
    .i_mem_op    (i_mem_op),
    .i_wb_dat    (i_wb_dat),
    .i_wb_ack    (i_wb_ack),
    .o_wb_cyc    (o_wb_cyc),
    .o_wb_stb    (o_wb_stb),
    .o_wb_we     (o_wb_we),
    .o_wb_adr    (o_wb_adr),
    .o_wb_sel    (o_wb_sel),
    .o_wb_dat    (o_wb_dat),
    .o_load_data (load_data),
    .o_mem_done  (mem_done)
  );

  exu_commit u_commit (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (i_valid),
    .i_pc         (i_pc),
    .i_rs1        (i_rs1),
    .i_imm        (i_imm),
    .i_branch     (i_branch),
    .i_mem_op     (i_mem_op),
    .i_wb_sel     (i_wb_sel),
    .i_rd_en      (i_rd_en),
    .i_invalid    (i_invalid),
    .i_alu_result (alu_result),
    .i_zero       (zero),
    .i_less       (less),
    .i_load_data  (load_data),
    .i_mem_done   (mem_done),
    .o_ready      (o_ready),
    .o_start      (start),
    .o_done       (o_done),
    .o_rd_we      (o_rd_we),
    .o_rd_data    (o_rd_data),
    .o_next_pc    (o_next_pc),
    .o_trap       (o_trap)
  );

endmodule

// ==== tb/exu_properties.sv ====
// concurrent assertions on the issue handshake and the wishbone bus, bound into exu_top
`timescale 1ns/1ns

module exu_properties (
  input logic                        i_clk,
  input logic                        i_rst_n,
  input logic                        i_ready,
  input logic                        i_start,
  input logic                        i_done,
  input logic                        i_wb_cyc,
  input logic                        i_wb_stb,
  input logic                        i_wb_we,
  input logic [exu_pkg::XLEN-1:0]     i_wb_adr,
  input logic [exu_pkg::XLEN-1:0]     i_wb_dat,
  input logic [exu_pkg::WB_SEL_W-1:0] i_wb_sel,
  input logic                        i_wb_ack
);

  // stb only inside cyc, both dropped in the cycle after ack
  a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_wb_stb |-> i_wb_cyc ##1 (!$past(i_wb_ack) || (!i_wb_stb && !i_wb_cyc)))
    else $error("wishbone stb outside cyc or held after ack");

  // request held until ack
  a_req_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_wb_stb && !i_wb_ack) |=> (i_wb_stb && $stable(i_wb_adr) && $stable(i_wb_dat)
                                 && $stable(i_wb_sel) && $stable(i_wb_we)))
    else $error("wishbone request changed while waiting for ack");

  // busy right after the accept edge
  a_start_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_start |-> i_ready ##1 !i_ready)
    else $error("start pulsed while not ready, or ready kept after start");

  a_done_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_done |=> !i_done) else $error("done high on two cycles in a row");

endmodule

bind exu_top exu_properties u_props (
  .i_clk    (i_clk),
  .i_rst_n  (i_rst_n),
  .i_ready  (o_ready),
  .i_start  (start),
  .i_done   (o_done),
  .i_wb_cyc (o_wb_cyc),
  .i_wb_stb (o_wb_stb),
  .i_wb_we  (o_wb_we),
  .i_wb_adr (o_wb_adr),
  .i_wb_dat (o_wb_dat),
  .i_wb_sel (o_wb_sel),
  .i_wb_ack (i_wb_ack)
);

// ==== tb/exu_tb.sv ====
// execute stage testbench: clock, reset, random stimulus, reference model, memory mirror, checks
`timescale 1ns/1ns

module exu_tb;

  localparam int N_INSTR = 400;
  localparam int LIMIT   = N_INSTR * 20;

  logic                        clk;
  logic                        rst_n;
  logic                        valid;
  logic [exu_pkg::XLEN-1:0]     pc;
  logic [exu_pkg::XLEN-1:0]     rs1;
  logic [exu_pkg::XLEN-1:0]     rs2;
  logic [exu_pkg::XLEN-1:0]     imm;
  exu_pkg::a_src_e             a_src;
  exu_pkg::b_src_e             b_src;
  exu_pkg::alu_op_e            alu_op;
  logic                        word_cut;
  exu_pkg::branch_e            branch;
  exu_pkg::mem_op_e            mem_op;
  exu_pkg::wb_sel_e            wb_sel;
  logic                        rd_en;
  logic                        invalid;
  logic                        ready;
  logic                        done;
  logic                        rd_we;
  logic [exu_pkg::XLEN-1:0]     rd_data;
  logic [exu_pkg::XLEN-1:0]     next_pc;
  logic                        trap;
  logic                        wb_cyc;
  logic                        wb_stb;
  logic                        wb_we;
  logic [exu_pkg::XLEN-1:0]     wb_adr;
  logic [exu_pkg::WB_SEL_W-1:0] wb_bsel;
  logic [exu_pkg::XLEN-1:0]     wb_wdat;
  logic [exu_pkg::XLEN-1:0]     wb_rdat;
  logic                        wb_ack;

  logic [exu_pkg::XLEN-1:0] mirror [0:63];  // same layout as the memory model
  logic [exu_pkg::XLEN-1:0] exp_data;
  logic [exu_pkg::XLEN-1:0] exp_pc;
  logic                     exp_we;
  logic                     exp_trap;
  logic                     exp_mem;
  logic [exu_pkg::XLEN-1:0] exp_adr;
  logic [exu_pkg::WB_SEL_W-1:0] exp_sel;
  logic [exu_pkg::XLEN-1:0] exp_wdat;  // store lanes only
  logic                     exp_store;
  logic                     pending;
  integer                   seed;
  int                       errors;
  int                       checks;
  int                       n_done;
  int                       n_xfer;
  int                       cycle;
  int                       accept_edge;

  exu_top u_dut (
    .i_clk (clk), .i_rst_n (rst_n), .i_valid (valid),
    .i_pc (pc), .i_rs1 (rs1), .i_rs2 (rs2), .i_imm (imm),
    .i_a_src (a_src), .i_b_src (b_src), .i_alu_op (alu_op), .i_word_cut (word_cut),
    .i_branch (branch), .i_mem_op (mem_op), .i_wb_sel (wb_sel),
    .i_rd_en (rd_en), .i_invalid (invalid),
    .o_ready (ready), .o_done (done), .o_rd_we (rd_we), .o_rd_data (rd_data),
    .o_next_pc (next_pc), .o_trap (trap),
    .o_wb_cyc (wb_cyc), .o_wb_stb (wb_stb), .o_wb_we (wb_we), .o_wb_adr (wb_adr),
    .o_wb_sel (wb_bsel), .o_wb_dat (wb_wdat), .i_wb_dat (wb_rdat), .i_wb_ack (wb_ack)
  );

  exu_wb_mem u_mem (
    .i_clk (clk), .i_cyc (wb_cyc), .i_stb (wb_stb), .i_we (wb_we), .i_adr (wb_adr),
    .i_sel (wb_bsel), .i_dat (wb_wdat), .o_dat (wb_rdat), .o_ack (wb_ack)
  );

  task automatic check_data(input logic [exu_pkg::XLEN-1:0] got,
                            input logic [exu_pkg::XLEN-1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_pc(input logic [exu_pkg::XLEN-1:0] got,
                          input logic [exu_pkg::XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: next pc is %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_sel(input logic [exu_pkg::WB_SEL_W-1:0] got,
                           input logic [exu_pkg::WB_SEL_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: o_wb_sel is %h, expected %h", $time, got, exp);
    end
  endtask

  function automatic logic [exu_pkg::XLEN-1:0] lane_mask(
      input logic [exu_pkg::WB_SEL_W-1:0] sel);
    logic [exu_pkg::XLEN-1:0] m;
    for (int b = 0; b < exu_pkg::WB_SEL_W; b++) begin
      m[8 * b +: 8] = {8{sel[b]}};
    end
    return m;
  endfunction

  function automatic int mem_size(input exu_pkg::mem_op_e op);
    case (op)
      exu_pkg::MEM_LB, exu_pkg::MEM_LBU, exu_pkg::MEM_SB: return 1;
      exu_pkg::MEM_LH, exu_pkg::MEM_LHU, exu_pkg::MEM_SH: return 2;
      exu_pkg::MEM_LW, exu_pkg::MEM_LWU, exu_pkg::MEM_SW: return 4;
      default:                                            return 8;
    endcase
  endfunction

  // rv64 alu rules, *w forms sign-extend the low word
  function automatic logic [63:0] alu_model(input exu_pkg::alu_op_e op,
      input logic [63:0] a, input logic [63:0] b, input logic word);
    logic [63:0] y;
    logic [63:0] a_sh;
    logic [5:0]  sh;
    sh = word ? {1'b0, b[4:0]} : b[5:0];
    a_sh = a;
    if (word) a_sh = (op == exu_pkg::ALU_SRA) ? {{32{a[31]}}, a[31:0]} : {32'd0, a[31:0]};
    case (op)
      exu_pkg::ALU_ADD:  y = a + b;
      exu_pkg::ALU_SUB:  y = a + ~b + 64'd1;
      exu_pkg::ALU_SLL:  y = a << sh;
      exu_pkg::ALU_SLT:  y = (a[63] != b[63]) ? {63'd0, a[63]} : {63'd0, a < b};
      exu_pkg::ALU_SLTU: y = {63'd0, a < b};
      exu_pkg::ALU_XOR:  y = a ^ b;
      exu_pkg::ALU_SRL:  y = a_sh >> sh;
      exu_pkg::ALU_SRA:  y = (a_sh >> sh) | (a_sh[63] ? ~(~64'd0 >> sh) : 64'd0);
      exu_pkg::ALU_OR:   y = a | b;
      exu_pkg::ALU_AND:  y = a & b;
      default:           y = b;  // copy of b for lui
    endcase
    if (word) y = {{32{y[31]}}, y[31:0]};
    return y;
  endfunction

  function automatic logic branch_taken(input exu_pkg::branch_e br, input exu_pkg::alu_op_e op,
                                        input logic [63:0] a, input logic [63:0] b);
    logic lt;
    lt = (op == exu_pkg::ALU_SLTU) ? (a < b) : ($signed(a) < $signed(b));
    case (br)
      exu_pkg::BR_BEQ: return a == b;
      exu_pkg::BR_BNE: return a != b;
      exu_pkg::BR_BLT: return lt;
      exu_pkg::BR_BGE: return !lt;
      default:         return 1'b0;
    endcase
  endfunction

  function automatic logic [63:0] load_model(input logic [63:0] addr,
                                             input exu_pkg::mem_op_e op);
    logic [63:0] raw;
    logic [63:0] mask;
    int          size;
    size = mem_size(op);
    raw  = mirror[addr[8:3]] >> (8 * addr[2:0]);
    mask = (size == 8) ? ~64'd0 : ((64'd1 << (8 * size)) - 64'd1);
    raw  = raw & mask;
    if (op inside {exu_pkg::MEM_LB, exu_pkg::MEM_LH, exu_pkg::MEM_LW} && raw[8*size-1]) begin
      raw = raw | ~mask;
    end
    return raw;
  endfunction

  task automatic store_mirror(input logic [63:0] addr, input logic [63:0] data, input int size);
    for (int k = 0; k < size; k++) begin
      mirror[addr[8:3]][8 * (addr[2:0] + k) +: 8] = data[8 * k +: 8];
    end
  endtask

  // fields change every cycle while busy, none of it may be accepted
  task automatic drive_garbage();
    logic [31:0] r;
    r       = $random(seed);
    valid   = 1'b1;
    pc      = {$random(seed), $random(seed)};
    rs1     = {$random(seed), $random(seed)};
    rs2     = {$random(seed), $random(seed)};
    imm     = {$random(seed), $random(seed)};
    alu_op  = exu_pkg::alu_op_e'(r[7:4] % 4'd11);
    mem_op  = exu_pkg::mem_op_e'(r[11:8] % 4'd12);
    rd_en   = r[12];
    invalid = r[13];
  endtask

  task automatic make_instr();
    logic [31:0] r;
    logic [31:0] r2;
    logic [63:0] addr;
    logic [63:0] opa;
    logic [63:0] opb;
    int          size;
    r  = $random(seed);
    r2 = $random(seed);
    pc  = {$random(seed), $random(seed)} & ~64'h3;
    rs1 = {$random(seed), $random(seed)};
    rs2 = {$random(seed), $random(seed)};
    imm = r2[0] ? {{52{r2[31]}}, r2[31:20]} : {{32{r2[31]}}, r2[31:12], 12'h000};
    a_src    = exu_pkg::A_RS1;
    b_src    = exu_pkg::B_RS2;
    alu_op   = exu_pkg::ALU_ADD;
    word_cut = 1'b0;
    branch   = exu_pkg::BR_NONE;
    mem_op   = exu_pkg::MEM_NONE;
    wb_sel   = exu_pkg::WB_ALU;
    rd_en    = 1'b1;
    invalid  = 1'b0;
    exp_pc   = pc + 64'd4;
    exp_mem  = 1'b0;
    exp_adr   = '0;
    exp_sel   = '0;
    exp_wdat  = '0;
    exp_store = 1'b0;
    case (r[2:0])
      3'd3: begin
        case (r[9:8])
          2'd0:    branch = exu_pkg::BR_BEQ;
          2'd1:    branch = exu_pkg::BR_BNE;
          2'd2:    branch = exu_pkg::BR_BLT;
          default: branch = exu_pkg::BR_BGE;
        endcase
        if (branch inside {exu_pkg::BR_BEQ, exu_pkg::BR_BNE}) alu_op = exu_pkg::ALU_SUB;
        else alu_op = r[10] ? exu_pkg::ALU_SLTU : exu_pkg::ALU_SLT;
        if (r[11]) rs2 = rs1;  // equal operands now and then
        rd_en = r[12];
        if (branch_taken(branch, alu_op, rs1, rs2)) exp_pc = pc + imm;
      end
      3'd4: begin
        branch = r[8] ? exu_pkg::BR_JALR : exu_pkg::BR_JAL;
        a_src  = exu_pkg::A_PC;
        b_src  = exu_pkg::B_FOUR;
        exp_pc = ((branch == exu_pkg::BR_JALR) ? rs1 : pc) + imm;
      end
      3'd5, 3'd6: begin
        if (r[2:0] == 3'd5) mem_op = exu_pkg::mem_op_e'(4'd8 + r[9:8]);
        else mem_op = exu_pkg::mem_op_e'(r[10:8] % 3'd7 + 3'd1);
        size    = mem_size(mem_op);
        addr    = {55'd0, r2[8:3], r2[2:0] & ~3'(size - 1)};  // size aligned
        imm     = {{52{r[31]}}, r[31:20]};
        rs1     = addr - imm;
        b_src   = exu_pkg::B_IMM;
        exp_mem = 1'b1;
        exp_adr   = {addr[63:3], 3'b000};
        exp_store = (r[2:0] == 3'd5);
        for (int k = 0; k < size; k++) begin
          exp_sel[addr[2:0] + k]             = 1'b1;
          exp_wdat[8 * (addr[2:0] + k) +: 8] = rs2[8 * k +: 8];
        end
        if (r[2:0] == 3'd5) begin
          rd_en = 1'b0;
          store_mirror(addr, rs2, size);
        end else begin
          wb_sel   = exu_pkg::WB_MEM;
          exp_data = load_model(addr, mem_op);
        end
      end
      3'd7: begin
        invalid = 1'b1;
        alu_op  = exu_pkg::alu_op_e'(r[11:8] % 4'd11);
        branch  = r[13] ? exu_pkg::BR_JALR : (r[12] ? exu_pkg::BR_JAL : exu_pkg::BR_BNE);
      end
      default: begin
        alu_op   = exu_pkg::alu_op_e'(r[11:8] % 4'd11);
        a_src    = exu_pkg::a_src_e'(r[12]);
        b_src    = exu_pkg::b_src_e'(r[14:13] % 2'd3);
        word_cut = r[15] && (alu_op inside {exu_pkg::ALU_ADD, exu_pkg::ALU_SUB,
                     exu_pkg::ALU_SLL, exu_pkg::ALU_SRL, exu_pkg::ALU_SRA});
        rd_en    = r[16] | r[17];
      end
    endcase
    opa = (a_src == exu_pkg::A_PC) ? pc : rs1;
    opb = (b_src == exu_pkg::B_RS2) ? rs2 : ((b_src == exu_pkg::B_IMM) ? imm : 64'd4);
    if (wb_sel == exu_pkg::WB_ALU) exp_data = alu_model(alu_op, opa, opb, word_cut);
    exp_we   = rd_en && !invalid;
    exp_trap = invalid;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle > LIMIT) begin
      $display("timeout after %0d cycles, %0d of %0d instructions done", LIMIT, n_done, N_INSTR);
      $display("TEST FAILED");
      $finish;
    end
  end

  // accept and done seen between edges, where both are stable
  always @(negedge clk) begin
    if (rst_n) begin
      if (valid && ready) begin
        accept_edge = cycle + 1;
        n_xfer      = 0;
      end
      if (wb_cyc && wb_ack) begin
        n_xfer++;
        check_data(wb_adr, exp_adr, "o_wb_adr");
        check_sel(wb_bsel, exp_sel);
        check_flag(wb_we, exp_store, "o_wb_we");
        if (exp_store) check_data(wb_wdat & lane_mask(exp_sel), exp_wdat, "o_wb_dat lanes");
      end
      if (done) begin
        if (!pending) begin
          errors++;
          $display("o_done at %0t with no accepted instruction outstanding", $time);
        end else begin
          pending = 1'b0;
          n_done++;
          if (exp_mem ? (cycle < accept_edge + 2) : (cycle != accept_edge + 1)) begin
            errors++;
            $display("FAILED %0t: done %0d cycles after accept", $time, cycle - accept_edge);
          end
          if (n_xfer != (exp_mem ? 1 : 0)) begin
            errors++;
            $display("FAILED %0t: %0d bus transfers for one instruction", $time, n_xfer);
          end
          check_flag(ready, 1'b0, "o_ready in done cycle");
          check_flag(rd_we, exp_we, "o_rd_we");
          check_flag(trap, exp_trap, "o_trap");
          check_pc(next_pc, exp_pc);
          if (exp_we) check_data(rd_data, exp_data, "o_rd_data");
        end
      end
    end
  end

  initial begin
    seed = 32'h594a_3a26;
    errors = 0;
    checks = 0;
    n_done = 0;
    n_xfer = 0;
    cycle = 0;
    accept_edge = 0;
    pending = 1'b0;
    rst_n = 1'b0;
    valid = 1'b0;
    pc = '0;
    rs1 = '0;
    rs2 = '0;
    imm = '0;
    a_src = exu_pkg::A_RS1;
    b_src = exu_pkg::B_RS2;
    alu_op = exu_pkg::ALU_ADD;
    word_cut = 1'b0;
    branch = exu_pkg::BR_NONE;
    mem_op = exu_pkg::MEM_NONE;
    wb_sel = exu_pkg::WB_ALU;
    rd_en = 1'b0;
    invalid = 1'b0;
    for (int i = 0; i < 64; i++) begin
      mirror[i] = {~i[31:0] * 32'h9e37_79b9, i[31:0] * 32'h85eb_ca6b};
    end
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    check_flag(ready, 1'b1, "o_ready after reset");
    check_flag(done, 1'b0, "o_done after reset");
    check_flag(rd_we, 1'b0, "o_rd_we after reset");
    check_flag(trap, 1'b0, "o_trap after reset");
    check_flag(wb_cyc, 1'b0, "o_wb_cyc after reset");
    check_flag(wb_stb, 1'b0, "o_wb_stb after reset");
    for (int n = 0; n < N_INSTR; n++) begin
      while (!ready) begin
        drive_garbage();
        @(posedge clk);
        #1;
      end
      make_instr();
      valid   = 1'b1;
      pending = 1'b1;
      @(posedge clk);
      #1;
    end
    valid = 1'b0;
    while (pending) @(posedge clk);
    repeat (4) @(posedge clk);  // catch any stray done
    $display("%0d instructions done, %0d checks, %0d errors", n_done, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/exu_wb_mem.sv ====
// wishbone classic slave memory with random ack delay and byte-select writes
`timescale 1ns/1ns

module exu_wb_mem (
  input  logic                        i_clk,
  input  logic                        i_cyc,
  input  logic                        i_stb,
  input  logic                        i_we,
  input  logic [exu_pkg::XLEN-1:0]     i_adr,
  input  logic [exu_pkg::WB_SEL_W-1:0] i_sel,
  input  logic [exu_pkg::XLEN-1:0]     i_dat,
  output logic [exu_pkg::XLEN-1:0]     o_dat,
  output logic                        o_ack
);

  logic [exu_pkg::XLEN-1:0] mem [0:63];  // 64 doublewords, index from adr[8:3]
  logic [exu_pkg::XLEN-1:0] word;
  logic [31:0]              rnd;
  logic [1:0]               wait_cnt;
  integer                   seed;

  function automatic logic [63:0] fill_word(input logic [31:0] idx);
    return {~idx * 32'h9e37_79b9, idx * 32'h85eb_ca6b};
  endfunction

  initial begin
    seed     = 32'h594a_3a26;
    o_ack    = 1'b0;
    o_dat    = '0;
    wait_cnt = 2'd0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = fill_word(i);
    end
  end

  always @(posedge i_clk) begin
    if (i_cyc && i_stb && !o_ack) begin
      if (wait_cnt == 2'd0) begin
        word = mem[i_adr[8:3]];
        if (i_we) begin
          for (int b = 0; b < exu_pkg::WB_SEL_W; b++) begin
            if (i_sel[b]) word[8*b +: 8] = i_dat[8*b +: 8];
          end
          mem[i_adr[8:3]] <= word;
        end
        o_dat    <= word;
        o_ack    <= 1'b1;
        rnd       = $random(seed);
        wait_cnt <= rnd[1:0];  // delay for the next transfer
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end else begin
      o_ack <= 1'b0;
    end
  end

endmodule
